//--- src/agu_pkg.sv
// operation format constants shared by the address stage datapath modules
`default_nettype none

package agu_pkg;

  // address widths
  localparam int vaddr_w = 44;
  localparam int paddr_w = 44;

  // data cache banking
  localparam int bank_cnt = 32;
  localparam int bank_w = 5;
  localparam int max_span = 5;

  // 8 KiB pages, bit 7 picks the odd half line
  localparam int page_bits = 13;
  localparam int line_bit = 7;

  // operation size codes
  localparam int sz_w = 5;
  localparam logic [sz_w-1:0] sz_u8 = 5'd16;
  localparam logic [sz_w-1:0] sz_u16 = 5'd17;
  localparam logic [sz_w-1:0] sz_u32 = 5'd18;
  localparam logic [sz_w-1:0] sz_u64 = 5'd19;
  // 80 bit extended float
  localparam logic [sz_w-1:0] sz_ext = 5'd3;
  // 160 bit fill/spill
  localparam logic [sz_w-1:0] sz_spill = 5'd15;

  // access byte counts after size decode
  typedef enum logic [2:0] {
    sc_1,
    sc_2,
    sc_4,
    sc_8,
    sc_10,
    sc_16,
    sc_20
  } size_class_e;

endpackage

`default_nettype wire

//--- src/mmu_pkg.sv
// translation and system register definitions used by the address stage and walk arbiter
`default_nettype none

package mmu_pkg;

  // process root, low part goes in front of the virtual address
  localparam int root_w = 24;

  // TLB lookup address and entry layout
  localparam int tlb_ip_w = 65;
  localparam int tlb_phys_w = 31;
  localparam int tlb_entry_w = 33;
  // supervisor-only page
  localparam int tlb_sys_bit = 31;
  // page present, 0 faults
  localparam int tlb_na_bit = 32;

  // privilege levels
  localparam logic [1:0] cpl_kernel = 2'd0;
  localparam logic [1:0] cpl_user = 2'd3;

  // system register numbers
  localparam logic [15:0] csr_page = 16'h0040;
  localparam logic [15:0] csr_mflags = 16'h0041;

  // csr write word, meaning picked by the register number
  typedef union packed {
    struct packed {
      logic [root_w-1:0] root;
      logic [63-root_w:0] rsvd;
    } page;
    struct packed {
      logic [61:0] rsvd;
      logic [1:0] cpl;
    } flags;
  } csr_word_u;

  // fault numbers reported with the fault code
  localparam logic [8:0] fault_no_page = {6'd11, 1'b0, 2'd1};
  localparam logic [8:0] fault_no_none = {6'd0, 1'b0, 2'd2};

endpackage

`default_nettype wire

//--- src/agu_op_stage.sv
// one-deep operation register with page root and privilege registers and the stall logic
`default_nettype none

module agu_op_stage (
  input  logic clk,
  input  logic rst,
  input  logic rs_stall,
  input  logic bus_hold,
  input  logic pause_miss,
  input  logic op_en,
  input  logic [agu_pkg::vaddr_w-1:0] op_addr,
  input  logic [agu_pkg::sz_w-1:0] op_sz,
  input  logic op_st,
  input  logic op_split,
  input  logic [agu_pkg::bank_w-1:0] op_bank0,
  input  logic op_kernel,
  input  logic csr_en,
  input  logic [15:0] csr_no,
  input  mmu_pkg::csr_word_u csr_data,
  input  logic tlb_hit,
  input  logic walk_busy,
  input  logic ext_req,
  output logic stage_valid,
  output logic [agu_pkg::vaddr_w-1:0] stage_addr,
  output logic [agu_pkg::sz_w-1:0] stage_sz,
  output logic stage_st,
  output logic stage_split,
  output logic [agu_pkg::bank_w-1:0] stage_bank0,
  output logic [1:0] cpl,
  output logic [mmu_pkg::root_w-1:0] root,
  output logic [mmu_pkg::tlb_ip_w-1:0] tlb_addr,
  output logic do_stall,
  output logic mem_en,
  output logic mem_tlb_miss
);

  localparam int root_lo_w = mmu_pkg::tlb_ip_w - agu_pkg::vaddr_w;

  logic pause_q1;
  logic pause_q2;
  logic accept;

  // page-rooted lookup address
  assign tlb_addr = {root[root_lo_w-1:0], stage_addr};

  assign mem_tlb_miss = stage_valid & ~tlb_hit;
  assign do_stall = mem_tlb_miss | walk_busy | ext_req | bus_hold | pause_q2;
  assign mem_en = stage_valid & ~do_stall;
  assign accept = ~do_stall & ~rs_stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
      pause_q1 <= 1'b0;
      pause_q2 <= 1'b0;
    end else begin
      pause_q1 <= pause_miss;
      pause_q2 <= pause_q1;
      // issued op drops out here unless a new one takes its place
      if (accept) stage_valid <= op_en;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && op_en) begin
      stage_addr <= op_addr;
      stage_sz <= op_sz;
      stage_st <= op_st;
      stage_split <= op_split;
      stage_bank0 <= op_bank0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      root <= '0;
      cpl <= mmu_pkg::cpl_kernel;
    end else begin
      if (accept && op_en) cpl <= op_kernel ? mmu_pkg::cpl_kernel : mmu_pkg::cpl_user;
      // a csr write in the same cycle wins
      if (csr_en) begin
        case (csr_no)
          mmu_pkg::csr_page: root <= csr_data.page.root;
          mmu_pkg::csr_mflags: cpl <= csr_data.flags.cpl;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/agu_bank_mask.sv
// combinational size decode and cache bank access mask for the issued operation
`default_nettype none

module agu_bank_mask #(
  parameter int bank_cnt_p = 32,
  parameter int max_span_p = 5
) (
  input  logic [agu_pkg::sz_w-1:0] sz,
  input  logic [1:0] addr_low,
  input  logic [agu_pkg::bank_w-1:0] bank0,
  input  logic valid,
  output logic [bank_cnt_p-1:0] banks
);

  agu_pkg::size_class_e size_class;
  logic [4:0] byte_cnt;
  logic [4:0] end_byte;
  logic [2:0] quads;
  logic [2:0] span;
  logic [agu_pkg::bank_w-1:0] off;

  always_comb begin
    case (sz)
      agu_pkg::sz_u8: size_class = agu_pkg::sc_1;
      agu_pkg::sz_u16: size_class = agu_pkg::sc_2;
      agu_pkg::sz_u32: size_class = agu_pkg::sc_4;
      agu_pkg::sz_u64: size_class = agu_pkg::sc_8;
      agu_pkg::sz_ext: size_class = agu_pkg::sc_10;
      agu_pkg::sz_spill: size_class = agu_pkg::sc_20;
      // 128 bit int and float
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: size_class = agu_pkg::sc_16;
      5'd4, 5'd5, 5'd6: size_class = agu_pkg::sc_4;
      default: size_class = agu_pkg::sc_8;
    endcase
  end

  always_comb begin
    case (size_class)
      agu_pkg::sc_1: byte_cnt = 5'd1;
      agu_pkg::sc_2: byte_cnt = 5'd2;
      agu_pkg::sc_4: byte_cnt = 5'd4;
      agu_pkg::sc_10: byte_cnt = 5'd10;
      agu_pkg::sc_16: byte_cnt = 5'd16;
      agu_pkg::sc_20: byte_cnt = 5'd20;
      default: byte_cnt = 5'd8;
    endcase
  end

  // banks are 4 bytes wide, count the words touched
  assign end_byte = {3'b0, addr_low} + byte_cnt;
  assign quads = 3'((end_byte + 5'd3) >> 2);
  assign span = (quads > 3'(max_span_p)) ? 3'(max_span_p) : quads;

  always_comb begin
    for (int i = 0; i < bank_cnt_p; i++) begin
      // distance from the first bank, wrapping round
      off = agu_pkg::bank_w'(i) - bank0;
      banks[i] = valid && (off < agu_pkg::bank_w'(span));
    end
  end

endmodule

`default_nettype wire

//--- src/agu_translate.sv
// physical even/odd line address selection and registered page fault check
`default_nettype none

module agu_translate (
  input  logic clk,
  input  logic rst,
  input  logic rs_stall,
  input  logic [agu_pkg::vaddr_w-1:0] stage_addr,
  input  logic split,
  input  logic [1:0] cpl,
  input  logic issued,
  input  logic tlb_hit,
  input  logic [mmu_pkg::tlb_entry_w-1:0] tlb_entry0,
  input  logic [mmu_pkg::tlb_entry_w-1:0] tlb_entry1,
  output logic [agu_pkg::paddr_w-1:8] mem_addr_even,
  output logic [agu_pkg::paddr_w-1:8] mem_addr_odd,
  output logic mem_odd,
  output logic [1:0] mem_addr_low,
  output logic page_fault,
  output logic [7:0] fault_code,
  output logic [8:0] fault_no
);

  localparam int line_w = agu_pkg::page_bits - agu_pkg::line_bit;

  logic [line_w-1:0] cur_line;
  logic [line_w-1:0] next_line;
  logic [line_w-1:0] even_line;
  logic [line_w-1:0] odd_line;
  logic page_carry;
  logic [mmu_pkg::tlb_phys_w-1:0] phys0;
  logic [mmu_pkg::tlb_phys_w-1:0] phys1;
  logic [1:0] fault0;
  logic [1:0] fault1;
  logic [1:0] fault_now;
  logic [1:0] fault_q;
  logic issued_q;

  // line step, carry out means the next line sits in the next page
  assign cur_line = stage_addr[agu_pkg::page_bits-1:agu_pkg::line_bit];
  assign {page_carry, next_line} = (line_w + 1)'(cur_line) + 1'b1;

  assign mem_odd = stage_addr[agu_pkg::line_bit];
  assign mem_addr_low = stage_addr[1:0];

  assign even_line = mem_odd ? next_line : cur_line;
  assign odd_line = mem_odd ? cur_line : next_line;

  assign phys0 = tlb_entry0[mmu_pkg::tlb_phys_w-1:0];
  assign phys1 = tlb_entry1[mmu_pkg::tlb_phys_w-1:0];

  assign mem_addr_even = {(mem_odd & page_carry) ? phys1 : phys0, even_line[line_w-1:1]};
  // odd half is the next line only with bit 7 clear, and that step never carries
  assign mem_addr_odd = {phys0, odd_line[line_w-1:1]};

  // {privilege, not present}
  assign fault0 = {(cpl == mmu_pkg::cpl_user) & tlb_entry0[mmu_pkg::tlb_sys_bit],
                   ~tlb_entry0[mmu_pkg::tlb_na_bit]};
  assign fault1 = {(cpl == mmu_pkg::cpl_user) & tlb_entry1[mmu_pkg::tlb_sys_bit],
                   ~tlb_entry1[mmu_pkg::tlb_na_bit]};
  // second page only matters when the access really crosses into it
  assign fault_now = (fault0 | (fault1 & {2{page_carry & split}})) & {2{tlb_hit}};

  always_ff @(posedge clk) begin
    if (rst) begin
      fault_q <= 2'b0;
      issued_q <= 1'b0;
    end else if (!rs_stall) begin
      fault_q <= fault_now;
      issued_q <= issued;
    end
  end

  assign page_fault = (fault_q != 2'b0) & issued_q;
  assign fault_code = {4'b0, fault_q[1], 2'b0, fault_q[0]};
  assign fault_no = page_fault ? mmu_pkg::fault_no_page : mmu_pkg::fault_no_none;

endmodule

`default_nettype wire

//--- src/agu_walk_arbiter.sv
// page walk request arbiter for stage misses and the data and code side requesters
`default_nettype none

module agu_walk_arbiter (
  input  logic clk,
  input  logic rst,
  input  logic dreq_en,
  input  logic [29:0] dreq_addr,
  input  logic creq_en,
  input  logic [30:0] creq_addr,
  input  logic miss,
  input  logic [mmu_pkg::tlb_ip_w-1:0] miss_addr,
  input  logic [mmu_pkg::root_w-1:0] root,
  input  logic walk_ready,
  output logic walk_req,
  output logic [mmu_pkg::tlb_ip_w-1:0] walk_addr,
  output logic walk_busy,
  output logic dreq_ack
);

  localparam int root_lo_w = mmu_pkg::tlb_ip_w - agu_pkg::vaddr_w;

  logic busy;
  logic is_data;
  logic dpark;
  logic cpark;
  logic done;
  logic [mmu_pkg::tlb_ip_w-1:0] dreq_ip;
  logic [mmu_pkg::tlb_ip_w-1:0] creq_ip;
  logic [mmu_pkg::tlb_ip_w-1:0] dpark_addr;
  logic [mmu_pkg::tlb_ip_w-1:0] cpark_addr;

  // data side names a page pair, code side a single page
  assign dreq_ip = {root[root_lo_w-1:0], dreq_addr, {(agu_pkg::page_bits + 1){1'b0}}};
  assign creq_ip = {root[root_lo_w-1:0], creq_addr, {agu_pkg::page_bits{1'b0}}};

  // walk_req high marks the launch cycle, ready there does not count
  assign done = busy & ~walk_req & walk_ready & ~dreq_en & ~creq_en;
  assign dreq_ack = done & is_data;
  assign walk_busy = busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      is_data <= 1'b0;
      walk_req <= 1'b0;
      dpark <= 1'b0;
      cpark <= 1'b0;
    end else begin
      walk_req <= 1'b0;
      if (done) begin
        if (dpark) begin
          walk_addr <= dpark_addr;
          is_data <= 1'b1;
          dpark <= 1'b0;
          walk_req <= 1'b1;
        end else if (cpark) begin
          walk_addr <= cpark_addr;
          is_data <= 1'b0;
          cpark <= 1'b0;
          walk_req <= 1'b1;
        end else begin
          busy <= 1'b0;
          is_data <= 1'b0;
        end
      end else begin
        if (!busy) begin
          // data side first, then code side, then our own miss
          if (dreq_en) begin
            walk_addr <= dreq_ip;
            is_data <= 1'b1;
            busy <= 1'b1;
            walk_req <= 1'b1;
          end else if (creq_en) begin
            walk_addr <= creq_ip;
            is_data <= 1'b0;
            busy <= 1'b1;
            walk_req <= 1'b1;
          end else if (miss) begin
            walk_addr <= miss_addr;
            is_data <= 1'b0;
            busy <= 1'b1;
            walk_req <= 1'b1;
          end
        end
        if (dreq_en && busy) begin
          dpark <= 1'b1;
          dpark_addr <= dreq_ip;
        end
        if (creq_en && (busy || dreq_en)) begin
          cpark <= 1'b1;
          cpark_addr <= creq_ip;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/agu_top.sv
// load/store address stage top level, connects stage, bank mask, translation and walk arbiter
`default_nettype none

module agu_top #(
  parameter int bank_cnt_p = agu_pkg::bank_cnt,
  parameter int max_span_p = agu_pkg::max_span
) (
  input  logic clk,
  input  logic rst,
  input  logic rs_stall,
  input  logic bus_hold,
  input  logic pause_miss,
  input  logic op_en,
  input  logic op_st,
  input  logic op_split,
  input  logic op_kernel,
  input  logic [agu_pkg::vaddr_w-1:0] op_addr,
  input  logic [agu_pkg::sz_w-1:0] op_sz,
  input  logic [agu_pkg::bank_w-1:0] op_bank0,
  input  logic csr_en,
  input  logic [15:0] csr_no,
  input  mmu_pkg::csr_word_u csr_data,
  output logic [mmu_pkg::tlb_ip_w-1:0] tlb_addr,
  input  logic tlb_hit,
  input  logic [mmu_pkg::tlb_entry_w-1:0] tlb_entry0,
  input  logic [mmu_pkg::tlb_entry_w-1:0] tlb_entry1,
  input  logic dreq_en,
  input  logic creq_en,
  input  logic [29:0] dreq_addr,
  input  logic [30:0] creq_addr,
  output logic dreq_ack,
  output logic walk_req,
  output logic [mmu_pkg::tlb_ip_w-1:0] walk_addr,
  input  logic walk_ready,
  output logic do_stall,
  output logic mem_en,
  output logic mem_odd,
  output logic mem_split,
  output logic [agu_pkg::paddr_w-1:8] mem_addr_even,
  output logic [agu_pkg::paddr_w-1:8] mem_addr_odd,
  output logic [1:0] mem_addr_low,
  output logic [bank_cnt_p-1:0] mem_banks,
  output logic mem_tlb_miss,
  output logic page_fault,
  output logic [7:0] fault_code,
  output logic [8:0] fault_no
);

  logic ext_req;
  logic walk_busy;
  logic [agu_pkg::vaddr_w-1:0] stage_addr;
  logic [agu_pkg::sz_w-1:0] stage_sz;
  logic [agu_pkg::bank_w-1:0] stage_bank0;
  logic [1:0] cpl;
  logic [mmu_pkg::root_w-1:0] root;

  // any outside walk request holds the front end
  assign ext_req = dreq_en | creq_en;

  agu_op_stage stage0 (
    .clk(clk), .rst(rst), .rs_stall(rs_stall), .bus_hold(bus_hold), .pause_miss(pause_miss),
    .op_en(op_en), .op_addr(op_addr), .op_sz(op_sz), .op_st(op_st), .op_split(op_split),
    .op_bank0(op_bank0), .op_kernel(op_kernel),
    .csr_en(csr_en), .csr_no(csr_no), .csr_data(csr_data),
    .tlb_hit(tlb_hit), .walk_busy(walk_busy), .ext_req(ext_req),
    .stage_valid(), .stage_addr(stage_addr), .stage_sz(stage_sz), .stage_st(),
    .stage_split(mem_split), .stage_bank0(stage_bank0),
    .cpl(cpl), .root(root), .tlb_addr(tlb_addr),
    .do_stall(do_stall), .mem_en(mem_en), .mem_tlb_miss(mem_tlb_miss)
  );

  agu_bank_mask #(
    .bank_cnt_p(bank_cnt_p),
    .max_span_p(max_span_p)
  ) mask0 (
    .sz(stage_sz), .addr_low(mem_addr_low), .bank0(stage_bank0), .valid(mem_en),
    .banks(mem_banks)
  );

  agu_translate xlat0 (
    .clk(clk), .rst(rst), .rs_stall(rs_stall),
    .stage_addr(stage_addr), .split(mem_split), .cpl(cpl), .issued(mem_en),
    .tlb_hit(tlb_hit), .tlb_entry0(tlb_entry0), .tlb_entry1(tlb_entry1),
    .mem_addr_even(mem_addr_even), .mem_addr_odd(mem_addr_odd), .mem_odd(mem_odd),
    .mem_addr_low(mem_addr_low),
    .page_fault(page_fault), .fault_code(fault_code), .fault_no(fault_no)
  );

  agu_walk_arbiter walk0 (
    .clk(clk), .rst(rst),
    .dreq_en(dreq_en), .dreq_addr(dreq_addr), .creq_en(creq_en), .creq_addr(creq_addr),
    .miss(mem_tlb_miss), .miss_addr(tlb_addr), .root(root),
    .walk_ready(walk_ready), .walk_req(walk_req), .walk_addr(walk_addr),
    .walk_busy(walk_busy), .dreq_ack(dreq_ack)
  );

endmodule

`default_nettype wire

//--- tb/agu_assertions.sv
// bound checker for the address stage, models the issued op and compares mask, halves and faults
`default_nettype none

module agu_assertions #(
  parameter logic [30:0] phys_key = 31'h1234_5678
) (
  input logic clk,
  input logic rst,
  input logic rs_stall,
  input logic op_en,
  input logic op_kernel,
  input logic op_split,
  input logic [43:0] op_addr,
  input logic [4:0] op_sz,
  input logic [4:0] op_bank0,
  input logic csr_en,
  input logic [15:0] csr_no,
  input mmu_pkg::csr_word_u csr_data,
  input logic [64:0] tlb_addr,
  input logic tlb_hit,
  input logic do_stall,
  input logic mem_en,
  input logic mem_odd,
  input logic mem_split,
  input logic [1:0] mem_addr_low,
  input logic mem_tlb_miss,
  input logic [31:0] mem_banks,
  input logic [43:8] mem_addr_even,
  input logic [43:8] mem_addr_odd,
  input logic page_fault,
  input logic [7:0] fault_code,
  input logic [8:0] fault_no,
  input logic walk_req,
  input logic [64:0] walk_addr,
  input logic walk_ready,
  input logic dreq_en,
  input logic [29:0] dreq_addr,
  input logic dreq_ack
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [43:0] s_addr;
  logic [4:0] s_sz;
  logic [4:0] s_bank0;
  logic s_kernel;
  logic s_split;
  logic s_valid;
  logic [20:0] root_m;
  logic [29:0] d_addr;
  logic [31:0] exp_banks;
  logic [36:0] line_a;
  logic [36:0] line_b;
  logic [36:0] ev;
  logic [36:0] od;
  logic [35:0] exp_even;
  logic [35:0] exp_odd;
  logic [30:0] p1;
  logic carry;
  logic priv;
  logic np;
  logic [17:0] exp_now;
  logic [17:0] exp_q;
  logic rst_q = 1'b0;
  logic miss_ep;
  logic d_pend;
  int span;
  int walk_cnt;
  int e_banks = 0;
  int e_idle = 0;
  int e_addr = 0;
  int e_fault = 0;
  int e_miss = 0;
  int e_walks = 0;
  int e_ack = 0;
  int e_rst = 0;
  int e_root = 0;
  int e_dwalk = 0;
  int fail_cnt;

  assign fail_cnt = e_banks + e_idle + e_addr + e_fault + e_miss + e_walks + e_ack + e_rst +
                    e_root + e_dwalk;

  function automatic int byte_count(input logic [4:0] sz);
    case (sz)
      5'd16: return 1;
      5'd17: return 2;
      5'd18, 5'd4, 5'd5, 5'd6: return 4;
      5'd3: return 10;
      5'd15: return 20;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: return 16;
      default: return 8;
    endcase
  endfunction

  // copy of the op the stage took in
  always_ff @(posedge clk) begin
    if (!rst && op_en && !do_stall && !rs_stall) begin
      s_addr <= op_addr;
      s_sz <= op_sz;
      s_bank0 <= op_bank0;
      s_kernel <= op_kernel;
      s_split <= op_split;
    end
  end

  always_comb begin
    span = (int'(s_addr[1:0]) + byte_count(s_sz) + 3) / 4;
    if (span > 5) span = 5;
    for (int i = 0; i < 32; i++) begin
      exp_banks[i] = ((i - int'(s_bank0)) & 31) < span;
    end
    // whole line numbers, the step may run into the next page
    line_a = s_addr[43:7];
    line_b = line_a + 37'd1;
    ev = s_addr[7] ? line_b : line_a;
    od = s_addr[7] ? line_a : line_b;
    exp_even = {ev[36:6] ^ phys_key, ev[5:1]};
    exp_odd = {od[36:6] ^ phys_key, od[5:1]};
    p1 = s_addr[43:13] + 31'd1;
    carry = &s_addr[12:7];
    priv = !s_kernel && (s_addr[14] || (s_split && carry && p1[1]));
    np = s_addr[15] || (s_split && carry && p1[2]);
    exp_now = {priv | np, 4'b0, priv, 2'b0, np,
               (priv | np) ? mmu_pkg::fault_no_page : mmu_pkg::fault_no_none};
  end

  always_ff @(posedge clk) begin
    exp_q <= exp_now;
    rst_q <= rst;
  end

  // stage occupancy, page root, pending data request and walk pulses per miss
  always_ff @(posedge clk) begin
    if (rst) begin
      miss_ep <= 1'b0;
      walk_cnt <= 0;
      d_pend <= 1'b0;
      s_valid <= 1'b0;
      root_m <= '0;
    end else begin
      if (!do_stall && !rs_stall) s_valid <= op_en;
      // root sits in the top 24 bits of the write word
      if (csr_en && csr_no == mmu_pkg::csr_page) root_m <= csr_data[60:40];
      if (!miss_ep) begin
        miss_ep <= s_valid && !tlb_hit;
        walk_cnt <= 0;
      end else if (!do_stall) begin
        miss_ep <= 1'b0;
      end else if (walk_req) begin
        walk_cnt <= walk_cnt + 1;
      end
      if (dreq_en) begin
        d_pend <= 1'b1;
        d_addr <= dreq_addr;
      end else if (dreq_ack) begin
        d_pend <= 1'b0;
      end
    end
  end

  a_banks: assert property (@(posedge clk) disable iff (rst) mem_en |-> mem_banks == exp_banks)
    else begin
      e_banks++;
      $error("FAIL mem_banks got %h expected %h", $sampled(mem_banks), $sampled(exp_banks));
    end

  a_idle: assert property (@(posedge clk) disable iff (rst) !mem_en |-> mem_banks == '0)
    else begin
      e_idle++;
      $error("FAIL mem_banks got %h expected 0 while idle", $sampled(mem_banks));
    end

  a_addr: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> {mem_addr_even, mem_addr_odd, mem_odd, mem_addr_low, mem_split} ==
               {exp_even, exp_odd, s_addr[7], s_addr[1:0], s_split})
    else begin
      e_addr++;
      $error("FAIL mem_addr_even/odd/low mem_split got %h %h %h %h expected %h %h %h %h",
             $sampled(mem_addr_even), $sampled(mem_addr_odd), $sampled(mem_addr_low),
             $sampled(mem_split), $sampled(exp_even), $sampled(exp_odd),
             $sampled(s_addr[1:0]), $sampled(s_split));
    end

  a_root: assert property (@(posedge clk) disable iff (rst)
    s_valid |-> tlb_addr == {root_m, s_addr})
    else begin
      e_root++;
      $error("FAIL tlb_addr got %h expected %h", $sampled(tlb_addr),
             $sampled({root_m, s_addr}));
    end

  a_fault: assert property (@(posedge clk) disable iff (rst)
    mem_en && !rs_stall |=> {page_fault, fault_code, fault_no} == exp_q)
    else begin
      e_fault++;
      $error("FAIL page_fault/fault_code/fault_no got %h expected %h",
             $sampled({page_fault, fault_code, fault_no}), $sampled(exp_q));
    end

  a_miss: assert property (@(posedge clk) disable iff (rst)
    s_valid && !tlb_hit |-> mem_tlb_miss && do_stall && !mem_en)
    else begin
      e_miss++;
      $error("a missing op was issued, or it did not flag the miss and stall the front end");
    end

  a_walks: assert property (@(posedge clk) disable iff (rst) miss_ep && !do_stall |-> walk_cnt == 1)
    else begin
      e_walks++;
      $error("FAIL walk_req count got %h expected 1 for one miss", $sampled(walk_cnt));
    end

  a_dwalk: assert property (@(posedge clk) disable iff (rst)
    walk_req && d_pend |-> walk_addr == {root_m, d_addr, 14'b0})
    else begin
      e_dwalk++;
      $error("FAIL walk_addr got %h expected %h for the data request", $sampled(walk_addr),
             $sampled({root_m, d_addr, 14'b0}));
    end

  a_ack: assert property (@(posedge clk) disable iff (rst) dreq_ack |-> walk_ready && d_pend)
    else begin
      e_ack++;
      $error("dreq_ack pulsed without a pending data request or without walk_ready");
    end

  a_reset: assert property (@(posedge clk) rst_q |->
    !mem_en && !walk_req && !dreq_ack && !page_fault && !do_stall && mem_banks == '0)
    else begin
      e_rst++;
      $error("outputs were active during reset or in the cycle after it");
    end

endmodule

`default_nettype wire

//--- tb/agu_tb.sv
// testbench for the address stage, drives ops and walk requests with TLB and walker models
`default_nettype none

module agu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [30:0] tlb_key = 31'h1234_5678;
  localparam int n_ops = 24;
  localparam int n_miss = 4;
  // reset, csr write, each op, each miss and the outside request phase
  localparam int n_phases = 3 + n_ops + n_miss;
  localparam int cycle_limit = 40 * n_phases;

  logic clk = 1'b0;
  logic rst;
  logic rs_stall, bus_hold, pause_miss;
  logic op_en, op_st, op_split, op_kernel;
  logic [43:0] op_addr;
  logic [4:0] op_sz;
  logic [4:0] op_bank0;
  logic csr_en;
  logic [15:0] csr_no;
  mmu_pkg::csr_word_u csr_data;
  mmu_pkg::csr_word_u csr_word;
  logic [64:0] tlb_addr;
  logic tlb_hit;
  logic [32:0] tlb_entry0, tlb_entry1;
  logic dreq_en, creq_en, dreq_ack;
  logic [29:0] dreq_addr;
  logic [30:0] creq_addr;
  logic walk_req;
  logic walk_ready = 1'b0;
  logic [64:0] walk_addr;
  logic do_stall, mem_en, mem_odd, mem_split, mem_tlb_miss;
  logic [43:8] mem_addr_even, mem_addr_odd;
  logic [1:0] mem_addr_low;
  logic [31:0] mem_banks;
  logic page_fault;
  logic [7:0] fault_code;
  logic [8:0] fault_no;
  logic [30:0] filled_page;
  logic [43:0] a;
  int wait_cnt;
  int cycles = 0;

  agu_top dut0 (.*);

  bind agu_top agu_assertions chk0 (.*);

  always #10 clk = ~clk;

  // entry is {na, sys, phys}, bit 15 set means not present
  function automatic logic [32:0] tlb_lookup(input logic [30:0] vpage);
    return {~vpage[2], vpage[1], vpage ^ tlb_key};
  endfunction

  always_comb begin
    tlb_hit = !tlb_addr[13] || (tlb_addr[43:13] == filled_page);
    tlb_entry0 = tlb_lookup(tlb_addr[43:13]);
    tlb_entry1 = tlb_lookup(tlb_addr[43:13] + 31'd1);
  end

  // walker answers three cycles after the request and fills the page
  always @(posedge clk) begin
    if (rst) begin
      walk_ready <= 1'b0;
      wait_cnt <= 0;
      filled_page <= '1;
    end else if (walk_req) begin
      walk_ready <= 1'b0;
      wait_cnt <= 3;
    end else if (wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 1;
      if (wait_cnt == 1) begin
        walk_ready <= 1'b1;
        filled_page <= walk_addr[43:13];
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the stimulus did not complete", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic issue_op(input logic [43:0] addr, input logic [4:0] sz,
                          input logic [4:0] bank0, input logic kernel, input logic split);
    @(posedge clk);
    op_en <= 1'b1;
    op_addr <= addr;
    op_sz <= sz;
    op_bank0 <= bank0;
    op_kernel <= kernel;
    op_split <= split;
    @(negedge clk);
    while (do_stall) @(negedge clk);
    @(posedge clk);
    op_en <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'h4851));
    rst = 1'b1;
    {rs_stall, bus_hold, pause_miss, op_en, op_st, op_split, op_kernel} = '0;
    op_addr = '0;
    op_sz = '0;
    op_bank0 = '0;
    {csr_en, csr_no, csr_data} = '0;
    {dreq_en, creq_en, dreq_addr, creq_addr} = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // page root through the union view
    csr_word = '0;
    csr_word.page.root = 24'h3c_a5f1;
    @(posedge clk);
    csr_en <= 1'b1;
    csr_no <= mmu_pkg::csr_page;
    csr_data <= csr_word;
    @(posedge clk);
    csr_en <= 1'b0;

    for (int i = 0; i < n_ops; i++) begin
      a = {12'($urandom), 32'($urandom)};
      a[13] = 1'b0;
      // last line of the page, next line carries
      if (i % 4 == 0) a[12:7] = '1;
      issue_op(a, 5'($urandom), 5'($urandom), 1'($urandom), 1'($urandom));
    end

    for (int i = 0; i < n_miss; i++) begin
      a = {12'($urandom), 32'($urandom)};
      a[13] = 1'b1;
      issue_op(a, 5'($urandom), 5'($urandom), 1'($urandom), 1'($urandom));
    end
    @(negedge clk);
    while (do_stall) @(negedge clk);

    // code walk first, data request parks behind it
    @(posedge clk);
    creq_en <= 1'b1;
    creq_addr <= 31'($urandom);
    @(posedge clk);
    creq_en <= 1'b0;
    @(posedge clk);
    dreq_en <= 1'b1;
    dreq_addr <= 30'($urandom);
    @(posedge clk);
    dreq_en <= 1'b0;
    @(negedge clk);
    while (!dreq_ack) @(negedge clk);
    while (do_stall) @(negedge clk);
    repeat (3) @(posedge clk);

    $display("closing report: %0d assertion failures in %0d cycles", dut0.chk0.fail_cnt, cycles);
    if (dut0.chk0.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/agu_pkg.sv
src/mmu_pkg.sv
src/agu_op_stage.sv
src/agu_bank_mask.sv
src/agu_translate.sv
src/agu_walk_arbiter.sv
src/agu_top.sv
tb/agu_assertions.sv
tb/agu_tb.sv

//--- Makefile
# Verilator build and run of the address stage testbench

VERILATOR ?= verilator
TOP ?= agu_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass when the log holds the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
